// File: sam_settings.svh
/*
 * Shared constants for the SAM Coupe ASIC port block
 * I/O port numbers (low address byte)
 * ROM and external RAM page bases
 * MIDI transmit timing
 */

`ifndef SAM_SETTINGS_SVH
`define SAM_SETTINGS_SVH

// ======================================================================
// I/O ports, matched against addr[7:0]
// ======================================================================

`define SAM_PORT_LMPR 8'hFA
`define SAM_PORT_HMPR 8'hFB
`define SAM_PORT_BRDR 8'hFE
`define SAM_PORT_STAT 8'hF9
`define SAM_PORT_MIDI 8'hFD
// Printer port, used as a two channel DAC
`define SAM_PORT_LPTD 8'hE8
`define SAM_PORT_LPTS 8'hE9
// External RAM page registers for sections C and D
`define SAM_PORT_EXTC 8'h80
`define SAM_PORT_EXTD 8'h81

// ======================================================================
// Memory map
// ======================================================================

// ROM sits at page prefix 10h, followed by addr[15]
`define SAM_ROM_BASE 6'h10
// External RAM pages start here
`define SAM_EXT_BASE 9'h040

// MIDI timing, one enable per microsecond
`define SAM_CE1M_DIV    7'd96
`define SAM_MIDI_TIME   9'd319
`define SAM_MIDI_INT_AT 9'd15

`endif

// File: sam_pkg.sv
/*
 * Types shared by the SAM Coupe ASIC blocks
 * lmpr_t : low memory page register, raw byte or decoded fields
 * hmpr_t : high memory page register, raw byte or decoded fields
 */

package sam_pkg;

	// ==================================================================
	// LMPR (port FA)
	// ==================================================================

	typedef struct packed {
		logic       wp;        // write protect bank 0
		logic       rom1_on;   // ROM1 in bank 3
		logic       rom0_off;  // ROM0 out of bank 0
		logic [4:0] page_ab;
	} lmpr_fields_t;

	typedef union packed {
		logic [7:0]   raw;
		lmpr_fields_t f;
	} lmpr_t;

	// ==================================================================
	// HMPR (port FB)
	// ==================================================================

	typedef struct packed {
		logic       ext_on;
		// Video mode 3 colour bits, kept for read back only
		logic [1:0] mode3_hi;
		logic [4:0] page_cd;
	} hmpr_fields_t;

	typedef union packed {
		logic [7:0]   raw;
		hmpr_fields_t f;
	} hmpr_t;

endpackage

// File: sam_port_bus.sv
/*
 * I/O port bus front end
 * Rising edge detection on io_wr
 * Port decode into single cycle write strobes
 * Read data multiplexer for LMPR, HMPR, status and printer ports
 */

`include "sam_settings.svh"

module sam_port_bus import sam_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic        io_wr,
	input  logic        io_rd,
	input  lmpr_t       lmpr,
	input  hmpr_t       hmpr,
	input  logic        midi_int,
	output logic [7:0]  io_data,
	output logic        lmpr_we,
	output logic        hmpr_we,
	output logic        brdr_we,
	output logic        extc_we,
	output logic        extd_we,
	output logic        lptd_we,
	output logic        lpts_we,
	output logic        midi_we
);

	logic       io_wr_q;
	logic       wr_edge;
	logic [7:0] port;
	logic [7:0] rd_byte;

	// ==================================================================
	// Write edge
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// High only on the first clock io_wr is seen high
	assign wr_edge = io_wr & ~io_wr_q;
	assign port    = addr[7:0];

	// One strobe per edge, ports are distinct so at most one fires
	assign lmpr_we = wr_edge & (port == `SAM_PORT_LMPR);
	assign hmpr_we = wr_edge & (port == `SAM_PORT_HMPR);
	assign brdr_we = wr_edge & (port == `SAM_PORT_BRDR);
	assign extc_we = wr_edge & (port == `SAM_PORT_EXTC);
	assign extd_we = wr_edge & (port == `SAM_PORT_EXTD);
	assign lptd_we = wr_edge & (port == `SAM_PORT_LPTD);
	assign lpts_we = wr_edge & (port == `SAM_PORT_LPTS);
	assign midi_we = wr_edge & (port == `SAM_PORT_MIDI);

	// ==================================================================
	// Read data
	// ==================================================================

	always_comb begin
		case (port)
			// Keyboard and line/frame bits are gone, read as 1
			`SAM_PORT_STAT: rd_byte = {3'b111, ~midi_int, 4'b1111};
			`SAM_PORT_LMPR: rd_byte = lmpr.raw;
			`SAM_PORT_HMPR: rd_byte = hmpr.raw;
			// Fake printer, nothing attached
			`SAM_PORT_LPTD,
			`SAM_PORT_LPTS: rd_byte = 8'h00;
			default:        rd_byte = 8'hFF;
		endcase
	end

	// Bus floats high when not read
	assign io_data = io_rd ? rd_byte : 8'hFF;

endmodule

// File: sam_mem_map.sv
/*
 * Memory paging unit
 * LMPR, HMPR and external RAM page registers
 * Translation of CPU address to 25 bit memory address
 * ROM select and write permission
 */

`include "sam_settings.svh"

module sam_mem_map import sam_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  data_in,
	input  logic        lmpr_we,
	input  logic        hmpr_we,
	input  logic        extc_we,
	input  logic        extd_we,
	input  logic        ext_ram_off,
	output lmpr_t       lmpr,
	output hmpr_t       hmpr,
	output logic [24:0] mem_addr,
	output logic        rom_sel,
	output logic        mem_we_ok
);

	logic [7:0]  ext_c;
	logic [7:0]  ext_d;
	logic        ext_dis;
	logic        bank0;
	logic        rom0_hit;
	logic        rom1_hit;
	logic        ext_acc;
	logic [8:0]  ext_page;
	logic [4:0]  int_page;
	logic [10:0] page;

	// ==================================================================
	// Registers
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr    <= '0;
			hmpr    <= '0;
			ext_c   <= 8'h00;
			ext_d   <= 8'h00;
			// Disable option is sampled only while in reset
			ext_dis <= ext_ram_off;
		end else begin
			if (lmpr_we) lmpr.raw <= data_in;
			if (hmpr_we) hmpr.raw <= data_in;
			if (extc_we) ext_c <= data_in;
			if (extd_we) ext_d <= data_in;
		end
	end

	// ==================================================================
	// Address translation
	// ==================================================================

	assign bank0    = (addr[15:14] == 2'b00);
	assign rom0_hit = ~lmpr.f.rom0_off & bank0;
	assign rom1_hit = lmpr.f.rom1_on & (addr[15:14] == 2'b11);
	assign rom_sel  = rom0_hit | rom1_hit;

	// Upper 32K goes to external RAM when enabled
	assign ext_acc  = ~rom_sel & hmpr.f.ext_on & addr[15];
	assign ext_page = `SAM_EXT_BASE + {1'b0, addr[14] ? ext_d : ext_c};

	// AB pair for the low half, CD pair for the high half
	assign int_page = addr[15] ? hmpr.f.page_cd : lmpr.f.page_ab;

	always_comb begin
		if (rom_sel) begin
			page = {4'd0, `SAM_ROM_BASE, addr[15]};
		end else if (ext_acc) begin
			page = {2'd0, ext_page};
		end else begin
			// Odd bank takes the next page, no wrap at 32 pages
			page = {6'd0, int_page} + {10'd0, addr[14]};
		end
	end

	assign mem_addr = {page, addr[13:0]};

	assign mem_we_ok = ~rom_sel
		& ~(bank0 & lmpr.f.wp)
		& ~(ext_acc & ext_dis);

endmodule

// File: sam_midi_tx.sv
/*
 * MIDI out timing
 * 1 MHz clock enable divider
 * Pending flag, byte time countdown and MIDI interrupt
 */

`include "sam_settings.svh"

module sam_midi_tx (
	input  logic clk_sys,
	input  logic reset,
	input  logic midi_we,
	output logic midi_busy,
	output logic midi_int
);

	logic [6:0] div_cnt;
	logic       ce_1m;
	logic       pending;
	logic [8:0] tx_time;

	// ==================================================================
	// 1 MHz enable
	// ==================================================================

	assign ce_1m = (div_cnt == `SAM_CE1M_DIV - 7'd1);

	always_ff @(posedge clk_sys) begin
		if (reset || ce_1m) begin
			div_cnt <= 7'd0;
		end else begin
			div_cnt <= div_cnt + 7'd1;
		end
	end

	// ==================================================================
	// Byte timer
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending   <= 1'b0;
			tx_time   <= 9'd0;
			midi_busy <= 1'b0;
			midi_int  <= 1'b0;
		end else begin
			if (ce_1m) begin
				if (tx_time != 9'd0) begin
					tx_time <= tx_time - 9'd1;
					// Interrupt as the count lands on the threshold
					if (tx_time == `SAM_MIDI_INT_AT + 9'd1) midi_int <= 1'b1;
				end else begin
					midi_busy <= 1'b0;
					midi_int  <= 1'b0;
					if (pending) begin
						midi_busy <= 1'b1;
						tx_time   <= `SAM_MIDI_TIME;
						pending   <= 1'b0;
					end
				end
			end
			// A new write wins over the take on the same clock
			if (midi_we) pending <= 1'b1;
		end
	end

endmodule

// File: sam_sound_out.sv
/*
 * Border register and audio output
 * Printer port DAC data and strobe latches
 * Mixing of the ear bit and DAC channels into 16 bit samples
 */

module sam_sound_out (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [7:0]  data_in,
	input  logic        brdr_we,
	input  logic        lptd_we,
	input  logic        lpts_we,
	output logic [3:0]  border_color,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r
);

	logic [7:0]  brdr;
	logic [7:0]  dac_data;
	logic [7:0]  vox_l;
	logic [7:0]  vox_r;
	logic        stb_q;
	logic        ear;
	logic [18:0] mix_l;
	logic [18:0] mix_r;

	// ==================================================================
	// Latches
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			brdr     <= 8'h00;
			dac_data <= 8'h00;
			vox_l    <= 8'h00;
			vox_r    <= 8'h00;
			stb_q    <= 1'b0;
		end else begin
			if (brdr_we) brdr <= data_in;
			if (lptd_we) dac_data <= data_in;
			if (lpts_we) begin
				// Strobe bit 0 rising feeds left, falling feeds right
				if (~stb_q & data_in[0]) vox_l <= dac_data;
				if (stb_q & ~data_in[0]) vox_r <= dac_data;
				stb_q <= data_in[0];
			end
		end
	end

	// ==================================================================
	// Outputs
	// ==================================================================

	assign border_color = {brdr[5], brdr[2:0]};
	assign ear          = brdr[4];

	// Byte doubled to fill the range, ear adds a fixed level
	assign mix_l = {1'b0, vox_l, vox_l, 2'b00} + {1'b0, ear, 17'd0};
	assign mix_r = {1'b0, vox_r, vox_r, 2'b00} + {1'b0, ear, 17'd0};

	assign audio_l = mix_l[18:3];
	assign audio_r = mix_r[18:3];

endmodule

// File: sam_asic.sv
/*
 * SAM Coupe ASIC port block, top level
 * Port bus, memory map, MIDI timer and sound output
 */

module sam_asic import sam_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  data_in,
	input  logic        io_wr,
	input  logic        io_rd,
	input  logic        ext_ram_off,
	output logic [24:0] mem_addr,
	output logic        rom_sel,
	output logic        mem_we_ok,
	output logic [7:0]  io_data,
	output logic [3:0]  border_color,
	output logic        midi_busy,
	output logic        midi_int,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r
);

	lmpr_t lmpr;
	hmpr_t hmpr;
	logic  lmpr_we;
	logic  hmpr_we;
	logic  brdr_we;
	logic  extc_we;
	logic  extd_we;
	logic  lptd_we;
	logic  lpts_we;
	logic  midi_we;

	sam_port_bus port_bus_inst (
		.clk_sys(clk_sys), .reset(reset), .addr(addr),
		.io_wr(io_wr), .io_rd(io_rd),
		.lmpr(lmpr), .hmpr(hmpr), .midi_int(midi_int),
		.io_data(io_data),
		.lmpr_we(lmpr_we), .hmpr_we(hmpr_we), .brdr_we(brdr_we),
		.extc_we(extc_we), .extd_we(extd_we),
		.lptd_we(lptd_we), .lpts_we(lpts_we), .midi_we(midi_we)
	);

	sam_mem_map mem_map_inst (
		.clk_sys(clk_sys), .reset(reset), .addr(addr), .data_in(data_in),
		.lmpr_we(lmpr_we), .hmpr_we(hmpr_we),
		.extc_we(extc_we), .extd_we(extd_we), .ext_ram_off(ext_ram_off),
		.lmpr(lmpr), .hmpr(hmpr),
		.mem_addr(mem_addr), .rom_sel(rom_sel), .mem_we_ok(mem_we_ok)
	);

	sam_midi_tx midi_tx_inst (
		.clk_sys(clk_sys), .reset(reset), .midi_we(midi_we),
		.midi_busy(midi_busy), .midi_int(midi_int)
	);

	sam_sound_out sound_out_inst (
		.clk_sys(clk_sys), .reset(reset), .data_in(data_in),
		.brdr_we(brdr_we), .lptd_we(lptd_we), .lpts_we(lpts_we),
		.border_color(border_color), .audio_l(audio_l), .audio_r(audio_r)
	);

endmodule

// File: sam_assertions.sv
/*
 * Concurrent assertions bound to the SAM Coupe ASIC top level
 * MIDI interrupt framing, ROM write protection, known outputs
 */

module sam_assertions (
	input logic        clk_sys,
	input logic        reset,
	input logic [24:0] mem_addr,
	input logic        rom_sel,
	input logic        mem_we_ok,
	input logic [7:0]  io_data,
	input logic [3:0]  border_color,
	input logic        midi_busy,
	input logic        midi_int,
	input logic [15:0] audio_l,
	input logic [15:0] audio_r
);
	timeunit 1ns;
	timeprecision 100ps;

	// Interrupt only inside a byte time
	int_in_busy: assert property (@(posedge clk_sys) disable iff (reset)
		midi_int |-> midi_busy)
		else $error("midi_int high while midi_busy is low");

	rom_read_only: assert property (@(posedge clk_sys) disable iff (reset)
		rom_sel |-> !mem_we_ok)
		else $error("mem_we_ok high on a ROM access");

	outputs_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({mem_addr, rom_sel, mem_we_ok, io_data, border_color,
			midi_busy, midi_int, audio_l, audio_r}))
		else $error("unknown value on a top level output");

endmodule

bind sam_asic sam_assertions sam_assertions_inst (
	.clk_sys(clk_sys), .reset(reset), .mem_addr(mem_addr), .rom_sel(rom_sel),
	.mem_we_ok(mem_we_ok), .io_data(io_data), .border_color(border_color),
	.midi_busy(midi_busy), .midi_int(midi_int), .audio_l(audio_l), .audio_r(audio_r)
);

// File: tb_sam_asic.sv
/*
 * Testbench for the SAM Coupe ASIC port block
 * Seeded random port traffic checked against a reference model
 * Paging, port reads, audio mixing and MIDI byte timing
 */

`include "sam_settings.svh"

module tb_sam_asic;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  data_in;
	logic        io_wr;
	logic        io_rd;
	logic        ext_ram_off;
	logic [24:0] mem_addr;
	logic        rom_sel;
	logic        mem_we_ok;
	logic [7:0]  io_data;
	logic [3:0]  border_color;
	logic        midi_busy;
	logic        midi_int;
	logic [15:0] audio_l;
	logic [15:0] audio_r;

	// Model state
	logic [7:0]  m_lmpr;
	logic [7:0]  m_hmpr;
	logic [7:0]  m_extc;
	logic [7:0]  m_extd;
	logic [7:0]  m_brdr;
	logic [7:0]  m_dac;
	logic [7:0]  m_left;
	logic [7:0]  m_right;
	logic        m_stb;
	logic        m_extoff;

	sam_asic sam_asic_inst (.*);

	always #4 clk_sys = ~clk_sys;

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Waits at falling edges for midi_busy (sel 0) or midi_int (sel 1)
	task automatic wait_midi(input logic sel, input logic level, input int limit,
			input string what);
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		while ((sel ? midi_int : midi_busy) !== level) begin
			@(negedge clk_sys);
			cnt++;
			if (cnt > limit) begin
				$display("Timed out waiting for %s", what);
				$display("Some tests failed");
				$fatal(1, "wait limit reached");
			end
		end
	endtask

	// ==================================================================
	// Reference model
	// ==================================================================

	function automatic logic [7:0] read_expect(input logic [7:0] port, input logic irq);
		case (port)
			`SAM_PORT_STAT: return {3'b111, ~irq, 4'hF};
			`SAM_PORT_LMPR: return m_lmpr;
			`SAM_PORT_HMPR: return m_hmpr;
			`SAM_PORT_LPTD,
			`SAM_PORT_LPTS: return 8'h00;
			default:        return 8'hFF;
		endcase
	endfunction

	// Returns {write ok, ROM select, 25 bit address}
	function automatic logic [26:0] map_expect(input logic [15:0] a);
		logic        rom;
		logic        ext;
		logic [7:0]  ext_pg;
		logic [4:0]  base;
		logic [10:0] page;
		logic        we;
		rom = (a[15:14] == 2'd0 && !m_lmpr[5]) || (a[15:14] == 2'd3 && m_lmpr[6]);
		ext = !rom && m_hmpr[7] && a[15];
		ext_pg = a[14] ? m_extd : m_extc;
		base = a[15] ? m_hmpr[4:0] : m_lmpr[4:0];
		if (rom)
			page = 11'(`SAM_ROM_BASE) * 11'd2 + 11'(a[15]);
		else if (ext)
			page = 11'(`SAM_EXT_BASE) + 11'(ext_pg);
		else
			page = 11'(base) + 11'(a[14]);
		we = !rom && !(a[15:14] == 2'd0 && m_lmpr[7]) && !(ext && m_extoff);
		return {we, rom, page, a[13:0]};
	endfunction

	// Byte doubled into bits 17..2, ear worth 2^17, top 16 of 19 bits kept
	function automatic logic [15:0] mix_sample(input logic [7:0] v, input logic ear);
		logic [18:0] s;
		s = 19'(v) * 19'd1028 + (ear ? 19'h20000 : 19'h0);
		return s[18:3];
	endfunction

	task automatic model_write(input logic [7:0] port, input logic [7:0] v);
		case (port)
			`SAM_PORT_LMPR: m_lmpr = v;
			`SAM_PORT_HMPR: m_hmpr = v;
			`SAM_PORT_EXTC: m_extc = v;
			`SAM_PORT_EXTD: m_extd = v;
			`SAM_PORT_BRDR: m_brdr = v;
			`SAM_PORT_LPTD: m_dac = v;
			`SAM_PORT_LPTS: begin
				if (v[0] && !m_stb)
					m_left = m_dac;
				if (!v[0] && m_stb)
					m_right = m_dac;
				m_stb = v[0];
			end
			default: ;
		endcase
	endtask

	function automatic logic [7:0] page_port(input logic [1:0] sel);
		case (sel)
			2'd0:    return `SAM_PORT_LMPR;
			2'd1:    return `SAM_PORT_HMPR;
			2'd2:    return `SAM_PORT_EXTC;
			default: return `SAM_PORT_EXTD;
		endcase
	endfunction

	// ==================================================================
	// Bus tasks
	// ==================================================================

	task automatic do_reset(input logic off);
		@(posedge clk_sys);
		reset       <= 1'b1;
		ext_ram_off <= off;
		io_wr       <= 1'b0;
		repeat (5) @(posedge clk_sys);
		reset       <= 1'b0;
		// Flip the disable input, the latched value must hold
		ext_ram_off <= ~off;
		{m_lmpr, m_hmpr, m_extc, m_extd, m_brdr} = '0;
		{m_dac, m_left, m_right, m_stb} = '0;
		m_extoff = off;
	endtask

	task automatic port_write(input logic [7:0] port, input logic [7:0] v);
		@(posedge clk_sys);
		addr    <= {8'($urandom), port};
		data_in <= v;
		io_wr   <= 1'b1;
		repeat (2) @(posedge clk_sys);
		io_wr   <= 1'b0;
		@(posedge clk_sys);
		model_write(port, v);
	endtask

	task automatic read_check(input logic [7:0] port, input logic rd, input logic [7:0] exp,
			input string what);
		@(posedge clk_sys);
		addr  <= {8'($urandom), port};
		io_rd <= rd;
		@(negedge clk_sys);
		check(32'(io_data), 32'(exp), what);
	endtask

	task automatic map_check(input logic [15:0] a);
		logic [26:0] e;
		@(posedge clk_sys);
		addr <= a;
		@(negedge clk_sys);
		e = map_expect(a);
		check(32'(mem_addr), 32'(e[24:0]), "mem_addr");
		check(32'(rom_sel), 32'(e[25]), "rom_sel");
		check(32'(mem_we_ok), 32'(e[26]), "mem_we_ok");
	endtask

	task automatic audio_check();
		@(negedge clk_sys);
		check(32'(border_color), 32'({m_brdr[5], m_brdr[2:0]}), "border_color");
		check(32'(audio_l), 32'(mix_sample(m_left, m_brdr[4])), "audio_l");
		check(32'(audio_r), 32'(mix_sample(m_right, m_brdr[4])), "audio_r");
	endtask

	// ==================================================================
	// Test sequence
	// ==================================================================

	initial begin
		logic [7:0] v;
		logic [7:0] p;
		void'($urandom(32'h7d88_6f8f));
		reset       <= 1'b1;
		addr        <= 16'h0000;
		data_in     <= 8'h00;
		io_wr       <= 1'b0;
		io_rd       <= 1'b0;
		ext_ram_off <= 1'b0;

		do_reset(1'b0);
		read_check(`SAM_PORT_LMPR, 1'b1, 8'h00, "LMPR after reset");
		read_check(`SAM_PORT_HMPR, 1'b1, 8'h00, "HMPR after reset");
		read_check(`SAM_PORT_STAT, 1'b1, read_expect(`SAM_PORT_STAT, 1'b0),
			"status after reset");
		audio_check();
		check(32'(midi_busy), 32'd0, "midi_busy after reset");

		// Paging, with the external RAM disable latched both ways
		for (int pass = 0; pass < 2; pass++) begin
			do_reset(pass[0]);
			for (int i = 0; i < 40; i++) begin
				port_write(page_port(2'($urandom)), 8'($urandom));
				read_check(`SAM_PORT_LMPR, 1'b1, m_lmpr, "LMPR read back");
				read_check(`SAM_PORT_HMPR, 1'b1, m_hmpr, "HMPR read back");
				repeat (4) map_check(16'($urandom));
			end
		end

		// io_wr held high while data changes
		v = 8'($urandom);
		@(posedge clk_sys);
		addr    <= {8'h00, `SAM_PORT_LMPR};
		data_in <= v;
		io_wr   <= 1'b1;
		repeat (8) begin
			@(posedge clk_sys);
			data_in <= 8'($urandom);
		end
		io_wr <= 1'b0;
		model_write(`SAM_PORT_LMPR, v);
		read_check(`SAM_PORT_LMPR, 1'b1, m_lmpr, "LMPR after held write");

		for (int i = 0; i < 40; i++) begin
			p = 8'($urandom);
			read_check(p, 1'b1, read_expect(p, 1'b0), "random port read");
			read_check(p, 1'b0, 8'hFF, "port read with io_rd low");
		end
		read_check(`SAM_PORT_LPTD, 1'b1, 8'h00, "E8 read");
		read_check(`SAM_PORT_LPTS, 1'b1, 8'h00, "E9 read");

		for (int i = 0; i < 60; i++) begin
			case ($urandom % 3)
				0:       p = `SAM_PORT_BRDR;
				1:       p = `SAM_PORT_LPTD;
				default: p = `SAM_PORT_LPTS;
			endcase
			port_write(p, 8'($urandom));
			audio_check();
		end

		// One MIDI byte time
		port_write(`SAM_PORT_MIDI, 8'($urandom));
		wait_midi(1'b0, 1'b1, 200, "midi_busy to rise");
		wait_midi(1'b1, 1'b1, 320 * 96 + 200, "midi_int to rise");
		read_check(`SAM_PORT_STAT, 1'b1, read_expect(`SAM_PORT_STAT, 1'b1),
			"status with MIDI interrupt");
		wait_midi(1'b0, 1'b0, 320 * 96 + 200, "midi_busy to fall");
		check(32'(midi_int), 32'd0, "midi_int after byte time");

		$display("All tests passed");
		$finish;
	end

endmodule

// File: build.f
+incdir+.
sam_pkg.sv
sam_port_bus.sv
sam_mem_map.sv
sam_midi_tx.sv
sam_sound_out.sv
sam_asic.sv
sam_assertions.sv
tb_sam_asic.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SAM Coupe ASIC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_sam_asic -f build.f -o tb_sam_asic

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/tb_sam_asic > sim.log 2>&1 || true
cat sim.log

if grep -q "^All tests passed$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
